/* build.f */
verilog/swu_pkg.sv
verilog/swu_write_ctrl.sv
verilog/swu_window_gen.sv
verilog/swu_buffer_core.sv
verilog/swu_top.sv
dv/swu_tb.sv

/* dv/swu_tb.sv */
`timescale 1ns/10ps

module swu_tb;

   import swu_pkg::*;

   localparam int EFF_CHANNELS = DEF_IFM_CHANNELS / DEF_SIMD;
   localparam int FRAME_WORDS  = DEF_IFM_DIM * DEF_IFM_DIM * EFF_CHANNELS;
   localparam int OFM_DIM      = (DEF_IFM_DIM - DEF_KERNEL_DIM) / DEF_STRIDE + 1;
   localparam int WIN_WORDS    = DEF_KERNEL_DIM * DEF_KERNEL_DIM * EFF_CHANNELS;
   localparam int OUT_WORDS    = OFM_DIM * OFM_DIM * WIN_WORDS;
   localparam int DATA_W       = DEF_SIMD * DEF_IN_PREC;
   // low lanes carry the index, the top lane the frame number
   localparam int IDX_W        = DATA_W - DEF_IN_PREC;
   localparam int NUM_FRAMES   = 3;
   localparam int TIMEOUT      = 20000;

   logic              clk;
   logic              resetn;
   logic [DATA_W-1:0] in_data;
   logic              in_valid;
   logic              in_ready;
   logic [DATA_W-1:0] out_data;
   logic              out_valid;
   logic              out_ready;

   // stimulus modes
   logic in_on = 1'b0;
   logic in_always = 1'b0;
   logic out_on = 1'b0;
   logic hold_phase = 1'b0;

   logic in_hs = 1'b0;
   logic out_hs = 1'b0;
   int   in_idx = 0;
   int   in_frame = 0;
   int   out_idx = 0;
   int   out_frame = 0;
   int   err_count = 0;
   int   errs_at_start = 0;
   int   tests_run = 0;
   int   tests_failed = 0;

   logic [DATA_W-1:0] exp_word;
   logic [DATA_W-1:0] prev_out_data;

   swu_top UUT (
      .clk         (clk),
      .resetn      (resetn),
      .in_data_i   (in_data),
      .in_valid_i  (in_valid),
      .in_ready_o  (in_ready),
      .out_data_o  (out_data),
      .out_valid_o (out_valid),
      .out_ready_i (out_ready)
   );

   function automatic logic [DATA_W-1:0] make_word(input int frame, input int idx);
      return {DEF_IN_PREC'(frame), IDX_W'(idx)};
   endfunction

   // input index of output word idx within a frame
   function automatic int window_index(input int idx);
      int ch;
      int kw;
      int kh;
      int oc;
      int orow;
      ch   = idx % EFF_CHANNELS;
      kw   = (idx / EFF_CHANNELS) % DEF_KERNEL_DIM;
      kh   = (idx / (EFF_CHANNELS * DEF_KERNEL_DIM)) % DEF_KERNEL_DIM;
      oc   = (idx / WIN_WORDS) % OFM_DIM;
      orow = idx / (WIN_WORDS * OFM_DIM);
      return ((orow * DEF_STRIDE + kh) * DEF_IFM_DIM + oc * DEF_STRIDE + kw) * EFF_CHANNELS + ch;
   endfunction

   task automatic start_test();
      errs_at_start = err_count;
   endtask

   task automatic report_test(input string name);
      int errs;
      errs = err_count - errs_at_start;
      tests_run++;
      if (errs != 0) begin
         tests_failed++;
      end
      $display("test %s finished with %0d errors", name, errs);
   endtask

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //////////////////////////////
   // stimulus and reference model
   //////////////////////////////

   // both sides are stable at the falling edge
   always @(negedge clk) begin
      in_hs  = in_valid && in_ready;
      out_hs = out_valid && out_ready;
   end

   always @(posedge clk) begin
      prev_out_data <= out_data;
      if (in_hs) begin
         in_idx   <= (in_idx == FRAME_WORDS - 1) ? 0 : in_idx + 1;
         in_frame <= (in_idx == FRAME_WORDS - 1) ? in_frame + 1 : in_frame;
      end
      if (out_hs) begin
         out_idx   <= (out_idx == OUT_WORDS - 1) ? 0 : out_idx + 1;
         out_frame <= (out_idx == OUT_WORDS - 1) ? out_frame + 1 : out_frame;
      end
   end

   assign exp_word = make_word(out_frame, window_index(out_idx));

   initial begin : drive_inputs
      void'($urandom(32'h1477));
      in_data   = '0;
      in_valid  = 1'b0;
      out_ready = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         if (!in_on || in_frame >= NUM_FRAMES) begin
            in_valid = 1'b0;
         end else if (in_always) begin
            in_valid = 1'b1;
         end else begin
            in_valid = ($urandom % 4) != 0;
         end
         in_data   = make_word(in_frame, in_idx);
         out_ready = out_on && (($urandom % 3) != 0);
      end
   end

   //////////////////////////////
   // checks
   //////////////////////////////

   a_window_data : assert property (
      @(posedge clk) disable iff (!resetn)
      out_valid |-> out_data == exp_word
   ) else begin
      err_count++;
      $display("Mismatch out_data: got 0x%08h expected 0x%08h at %0t",
               $sampled(out_data), $sampled(exp_word), $time);
   end

   a_frame_field : assert property (
      @(posedge clk) disable iff (!resetn)
      out_valid |-> out_data[DATA_W-1 -: DEF_IN_PREC] == DEF_IN_PREC'(out_frame)
   ) else begin
      err_count++;
      $display("Mismatch out_data frame field: got 0x%02h expected 0x%02h",
               $sampled(out_data[DATA_W-1 -: DEF_IN_PREC]), DEF_IN_PREC'($sampled(out_frame)));
   end

   a_no_extra : assert property (
      @(posedge clk) disable iff (!resetn)
      out_frame >= NUM_FRAMES |-> !out_valid
   ) else begin
      err_count++;
      $display("output word appeared after the last frame at %0t", $time);
   end

   a_hold_valid : assert property (
      @(posedge clk) disable iff (!resetn)
      out_valid && !out_ready |=> out_valid
   ) else begin
      err_count++;
      $display("out_valid dropped under back-pressure at %0t", $time);
   end

   a_hold_data : assert property (
      @(posedge clk) disable iff (!resetn)
      out_valid && !out_ready |=> $stable(out_data)
   ) else begin
      err_count++;
      $display("Mismatch out_data under back-pressure: got 0x%08h expected 0x%08h",
               $sampled(out_data), $sampled(prev_out_data));
   end

   a_reset_idle : assert property (
      @(posedge clk) !resetn |=> !out_valid
   ) else begin
      err_count++;
      $display("out_valid high right after reset at %0t", $time);
   end

   // last two words may still be in flight once the final issue is done
   a_frame_closed : assert property (
      @(posedge clk) disable iff (!resetn)
      (in_frame > out_frame) && (out_idx < OUT_WORDS - 2) |-> !in_ready
   ) else begin
      err_count++;
      $display("in_ready high before frame %0d was read out at %0t", out_frame, $time);
   end

   a_stall_full : assert property (
      @(posedge clk) disable iff (!resetn)
      hold_phase && !in_ready |=> !in_ready
   ) else begin
      err_count++;
      $display("in_ready rose while the output was stalled at %0t", $time);
   end

   //////////////////////////////
   // test sequence
   //////////////////////////////

   initial begin : run_tests
      int cycles;
      resetn = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      resetn = 1'b1;

      start_test();
      repeat (4) @(negedge clk);
      report_test("reset_state");

      // stall the output until the buffer runs out of room
      start_test();
      hold_phase = 1'b1;
      in_always  = 1'b1;
      in_on      = 1'b1;
      cycles     = 0;
      while (!(in_idx > 0 && !in_ready) && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (cycles >= TIMEOUT) begin
         err_count++;
         $display("in_ready never dropped while the output was stalled");
      end else if (in_idx != DEF_BUFFER_SIZE) begin
         err_count++;
         $display("Mismatch input count at stall: got 0x%0h expected 0x%0h",
                  in_idx, DEF_BUFFER_SIZE);
      end
      repeat (30) @(negedge clk);
      hold_phase = 1'b0;
      out_on     = 1'b1;
      cycles     = 0;
      while (!in_ready && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (cycles >= TIMEOUT) begin
         err_count++;
         $display("in_ready stayed low after out_ready was released");
      end
      report_test("fill_stall");

      start_test();
      in_always = 1'b0;
      cycles    = 0;
      while (out_frame < NUM_FRAMES && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (cycles >= TIMEOUT) begin
         err_count++;
         $display("only %0d of %0d frames came out before the timeout", out_frame, NUM_FRAMES);
      end
      repeat (20) @(negedge clk);
      report_test("random_stream");

      $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_count);
      if (err_count == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the sliding window testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module swu_tb \
   -f build.f \
   --Mdir obj_dir -o swu_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/swu_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -q '^\*\*\* TEST PASSED \*\*\*$'; then
   exit 0
fi
exit 1

/* verilog/swu_buffer_core.sv */
`timescale 1ns/10ps

module swu_buffer_core #(
   parameter int SIMD         = swu_pkg::DEF_SIMD,
   parameter int IN_PREC      = swu_pkg::DEF_IN_PREC,
   parameter int IFM_CHANNELS = swu_pkg::DEF_IFM_CHANNELS,
   parameter int IFM_DIM      = swu_pkg::DEF_IFM_DIM,
   parameter int BUFFER_SIZE  = swu_pkg::DEF_BUFFER_SIZE,
   localparam int DATA_W       = SIMD * IN_PREC,
   localparam int EFF_CHANNELS = IFM_CHANNELS / SIMD,
   localparam int FRAME_WORDS  = IFM_DIM * IFM_DIM * EFF_CHANNELS,
   localparam int IDX_W        = $clog2(FRAME_WORDS) + 1
) (
   input  logic              clk,
   input  logic              resetn,
   input  logic [DATA_W-1:0] in_data_i,
   input  logic              wr_en_i,
   input  logic [IDX_W-1:0]  wr_count_i,
   input  logic [IDX_W-1:0]  rd_index_i,
   input  logic [IDX_W-1:0]  start_index_i,
   input  logic              out_ready_i,
   output logic              wr_room_o,
   output logic              issue_o,
   output logic [DATA_W-1:0] out_data_o,
   output logic              out_valid_o
);

   localparam int ADDR_W = $clog2(BUFFER_SIZE);

   logic [DATA_W-1:0] mem [BUFFER_SIZE];

   logic [ADDR_W-1:0] wr_addr;
   logic [ADDR_W-1:0] rd_addr;

   // distance from the oldest needed word to the next write
   logic [IDX_W-1:0] room_gap;
   logic             rd_avail;

   // read stage
   logic [DATA_W-1:0] rd_data;
   logic              rd_valid;

   // output stage
   logic [DATA_W-1:0] out_data;
   logic              out_valid;

   logic out_en;
   logic rd_en;

   //////////////////////////////
   // flow checks
   //////////////////////////////

   // writing index n overwrites index n - BUFFER_SIZE
   assign room_gap  = wr_count_i - start_index_i;
   assign wr_room_o = (32'(room_gap) < BUFFER_SIZE);

   // word already written
   assign rd_avail = (rd_index_i < wr_count_i);

   assign out_en  = !out_valid || out_ready_i;
   assign rd_en   = !rd_valid || out_en;
   assign issue_o = rd_avail && rd_en;

   //////////////////////////////
   // circular RAM
   //////////////////////////////

   assign wr_addr = wr_count_i[ADDR_W-1:0];
   assign rd_addr = rd_index_i[ADDR_W-1:0];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr] <= in_data_i;
      end
   end

   // registered read, held while the read stage is stalled
   always_ff @(posedge clk) begin
      if (issue_o) begin
         rd_data <= mem[rd_addr];
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         rd_valid <= 1'b0;
      end else if (rd_en) begin
         rd_valid <= issue_o;
      end
   end

   //////////////////////////////
   // output stage
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (out_en && rd_valid) begin
         out_data <= rd_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         out_valid <= 1'b0;
      end else if (out_en) begin
         out_valid <= rd_valid;
      end
   end

   assign out_data_o  = out_data;
   assign out_valid_o = out_valid;

   a_out_hold : assert property (
      @(posedge clk) disable iff (!resetn)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o)
   ) else $error("output word changed under back-pressure");

   // room is decided here, the write is granted by the write side
   a_wr_room : assert property (
      @(posedge clk) disable iff (!resetn)
      wr_en_i |-> wr_room_o
   ) else $error("write at count 0x%0h without room", wr_count_i);

endmodule

/* verilog/swu_pkg.sv */
// default geometry of the sliding window unit
// the top level copies these into its own parameters

package swu_pkg;

   //////////////////////////////
   // stream word format
   //////////////////////////////

   // lanes per input word
   parameter int DEF_SIMD = 4;

   // bits per lane
   parameter int DEF_IN_PREC = 8;

   //////////////////////////////
   // feature map and kernel
   //////////////////////////////

   // input channels, a multiple of DEF_SIMD
   parameter int DEF_IFM_CHANNELS = 8;

   // square input map, width and height
   parameter int DEF_IFM_DIM = 7;

   // square kernel
   parameter int DEF_KERNEL_DIM = 3;

   parameter int DEF_STRIDE = 2;

   //////////////////////////////
   // circular buffer
   //////////////////////////////

   // words, power of two, must hold one full window span
   parameter int DEF_BUFFER_SIZE = 64;

endpackage

/* verilog/swu_top.sv */
`timescale 1ns/10ps

module swu_top #(
   parameter int SIMD         = swu_pkg::DEF_SIMD,
   parameter int IN_PREC      = swu_pkg::DEF_IN_PREC,
   parameter int IFM_CHANNELS = swu_pkg::DEF_IFM_CHANNELS,
   parameter int IFM_DIM      = swu_pkg::DEF_IFM_DIM,
   parameter int KERNEL_DIM   = swu_pkg::DEF_KERNEL_DIM,
   parameter int STRIDE       = swu_pkg::DEF_STRIDE,
   parameter int BUFFER_SIZE  = swu_pkg::DEF_BUFFER_SIZE,
   localparam int DATA_W       = SIMD * IN_PREC,
   localparam int EFF_CHANNELS = IFM_CHANNELS / SIMD,
   localparam int FRAME_WORDS  = IFM_DIM * IFM_DIM * EFF_CHANNELS,
   localparam int IDX_W        = $clog2(FRAME_WORDS) + 1
) (
   input  logic              clk,
   input  logic              resetn,
   input  logic [DATA_W-1:0] in_data_i,
   input  logic              in_valid_i,
   output logic              in_ready_o,
   output logic [DATA_W-1:0] out_data_o,
   output logic              out_valid_o,
   input  logic              out_ready_i
);

   // words from the window origin to its last word, inclusive
   localparam int WINDOW_SPAN = ((KERNEL_DIM - 1) * IFM_DIM + KERNEL_DIM) * EFF_CHANNELS;

   logic             wr_en;
   logic             wr_room;
   logic [IDX_W-1:0] wr_count;
   logic [IDX_W-1:0] rd_index;
   logic [IDX_W-1:0] start_index;
   logic             issue;
   logic             frame_end;

   //////////////////////////////
   // elaboration checks
   //////////////////////////////

   if ((BUFFER_SIZE & (BUFFER_SIZE - 1)) != 0) begin : g_size_pow2
      $error("BUFFER_SIZE %0d is not a power of two", BUFFER_SIZE);
   end

   if (BUFFER_SIZE <= WINDOW_SPAN) begin : g_size_span
      $error("BUFFER_SIZE %0d cannot hold a window span of %0d", BUFFER_SIZE, WINDOW_SPAN);
   end

   // last window must end on the last input word of the frame
   if ((IFM_DIM - KERNEL_DIM) % STRIDE != 0) begin : g_stride_fit
      $error("stride %0d does not tile the input map", STRIDE);
   end

   swu_write_ctrl #(
      .SIMD         (SIMD),
      .IFM_CHANNELS (IFM_CHANNELS),
      .IFM_DIM      (IFM_DIM)
   ) u_write_ctrl (
      .clk         (clk),
      .resetn      (resetn),
      .in_valid_i  (in_valid_i),
      .wr_room_i   (wr_room),
      .frame_end_i (frame_end),
      .in_ready_o  (in_ready_o),
      .wr_en_o     (wr_en),
      .wr_count_o  (wr_count)
   );

   swu_window_gen #(
      .SIMD         (SIMD),
      .IFM_CHANNELS (IFM_CHANNELS),
      .IFM_DIM      (IFM_DIM),
      .KERNEL_DIM   (KERNEL_DIM),
      .STRIDE       (STRIDE)
   ) u_window_gen (
      .clk           (clk),
      .resetn        (resetn),
      .issue_i       (issue),
      .rd_index_o    (rd_index),
      .start_index_o (start_index),
      .frame_end_o   (frame_end)
   );

   swu_buffer_core #(
      .SIMD         (SIMD),
      .IN_PREC      (IN_PREC),
      .IFM_CHANNELS (IFM_CHANNELS),
      .IFM_DIM      (IFM_DIM),
      .BUFFER_SIZE  (BUFFER_SIZE)
   ) u_buffer_core (
      .clk           (clk),
      .resetn        (resetn),
      .in_data_i     (in_data_i),
      .wr_en_i       (wr_en),
      .wr_count_i    (wr_count),
      .rd_index_i    (rd_index),
      .start_index_i (start_index),
      .out_ready_i   (out_ready_i),
      .wr_room_o     (wr_room),
      .issue_o       (issue),
      .out_data_o    (out_data_o),
      .out_valid_o   (out_valid_o)
   );

endmodule

/* verilog/swu_window_gen.sv */
`timescale 1ns/10ps

module swu_window_gen #(
   parameter int SIMD         = swu_pkg::DEF_SIMD,
   parameter int IFM_CHANNELS = swu_pkg::DEF_IFM_CHANNELS,
   parameter int IFM_DIM      = swu_pkg::DEF_IFM_DIM,
   parameter int KERNEL_DIM   = swu_pkg::DEF_KERNEL_DIM,
   parameter int STRIDE       = swu_pkg::DEF_STRIDE,
   localparam int EFF_CHANNELS = IFM_CHANNELS / SIMD,
   localparam int FRAME_WORDS  = IFM_DIM * IFM_DIM * EFF_CHANNELS,
   localparam int IDX_W        = $clog2(FRAME_WORDS) + 1
) (
   input  logic             clk,
   input  logic             resetn,
   input  logic             issue_i,
   output logic [IDX_W-1:0] rd_index_o,
   output logic [IDX_W-1:0] start_index_o,
   output logic             frame_end_o
);

   localparam int OFM_DIM = (IFM_DIM - KERNEL_DIM) / STRIDE + 1;

   localparam int CH_W = (EFF_CHANNELS > 1) ? $clog2(EFF_CHANNELS) : 1;
   localparam int K_W  = (KERNEL_DIM > 1) ? $clog2(KERNEL_DIM) : 1;
   localparam int O_W  = (OFM_DIM > 1) ? $clog2(OFM_DIM) : 1;

   localparam logic [CH_W-1:0] CH_LAST = CH_W'(EFF_CHANNELS - 1);
   localparam logic [K_W-1:0]  K_LAST  = K_W'(KERNEL_DIM - 1);
   localparam logic [O_W-1:0]  O_LAST  = O_W'(OFM_DIM - 1);

   // index steps, so no multiply is needed per cycle
   localparam logic [IDX_W-1:0] ROW_WORDS  = IDX_W'(IFM_DIM * EFF_CHANNELS);
   localparam logic [IDX_W-1:0] COL_STEP   = IDX_W'(STRIDE * EFF_CHANNELS);
   localparam logic [IDX_W-1:0] LINE_STEP  = IDX_W'(STRIDE * IFM_DIM * EFF_CHANNELS);
   localparam logic [IDX_W-1:0] FRAME_LAST = IDX_W'(FRAME_WORDS);

   logic [CH_W-1:0] ch;
   logic [K_W-1:0]  kw;
   logic [K_W-1:0]  kh;
   logic [O_W-1:0]  oc;
   logic [O_W-1:0]  orow;

   // window origin of the current output row
   logic [IDX_W-1:0] line_start;
   // window origin of the current output pixel
   logic [IDX_W-1:0] start_index;
   // first word of the current kernel row
   logic [IDX_W-1:0] row_base;
   logic [IDX_W-1:0] rd_index;

   logic [IDX_W-1:0] next_row;
   logic [IDX_W-1:0] next_col;
   logic [IDX_W-1:0] next_line;

   logic ch_wrap;
   logic kw_wrap;
   logic kh_wrap;
   logic oc_wrap;
   logic orow_wrap;

   //////////////////////////////
   // wrap conditions
   //////////////////////////////

   // each level wraps only when every inner level wraps too
   assign ch_wrap   = (ch == CH_LAST);
   assign kw_wrap   = ch_wrap && (kw == K_LAST);
   assign kh_wrap   = kw_wrap && (kh == K_LAST);
   assign oc_wrap   = kh_wrap && (oc == O_LAST);
   assign orow_wrap = oc_wrap && (orow == O_LAST);

   assign frame_end_o = issue_i && orow_wrap;

   //////////////////////////////
   // window counters
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn || frame_end_o) begin
         ch   <= '0;
         kw   <= '0;
         kh   <= '0;
         oc   <= '0;
         orow <= '0;
      end else if (issue_i) begin
         ch <= ch_wrap ? '0 : ch + 1'b1;
         if (ch_wrap) begin
            kw <= kw_wrap ? '0 : kw + 1'b1;
         end
         if (kw_wrap) begin
            kh <= kh_wrap ? '0 : kh + 1'b1;
         end
         if (kh_wrap) begin
            oc <= oc_wrap ? '0 : oc + 1'b1;
         end
         if (oc_wrap) begin
            orow <= orow + 1'b1;
         end
      end
   end

   //////////////////////////////
   // absolute indices
   //////////////////////////////

   assign next_row  = row_base + ROW_WORDS;
   assign next_col  = start_index + COL_STEP;
   assign next_line = line_start + LINE_STEP;

   // channels and kernel columns are contiguous, so those steps are +1
   always_ff @(posedge clk) begin
      if (!resetn || frame_end_o) begin
         line_start  <= '0;
         start_index <= '0;
         row_base    <= '0;
         rd_index    <= '0;
      end else if (issue_i) begin
         if (!kw_wrap) begin
            rd_index <= rd_index + IDX_W'(1);
         end else if (!kh_wrap) begin
            row_base <= next_row;
            rd_index <= next_row;
         end else if (!oc_wrap) begin
            start_index <= next_col;
            row_base    <= next_col;
            rd_index    <= next_col;
         end else begin
            line_start  <= next_line;
            start_index <= next_line;
            row_base    <= next_line;
            rd_index    <= next_line;
         end
      end
   end

   assign rd_index_o    = rd_index;
   assign start_index_o = start_index;

   a_rd_in_frame : assert property (
      @(posedge clk) disable iff (!resetn)
      issue_i |-> (rd_index < FRAME_LAST)
   ) else $error("read index 0x%0h outside frame", rd_index);

endmodule

/* verilog/swu_write_ctrl.sv */
`timescale 1ns/10ps

module swu_write_ctrl #(
   parameter int SIMD         = swu_pkg::DEF_SIMD,
   parameter int IFM_CHANNELS = swu_pkg::DEF_IFM_CHANNELS,
   parameter int IFM_DIM      = swu_pkg::DEF_IFM_DIM,
   localparam int EFF_CHANNELS = IFM_CHANNELS / SIMD,
   localparam int FRAME_WORDS  = IFM_DIM * IFM_DIM * EFF_CHANNELS,
   localparam int IDX_W        = $clog2(FRAME_WORDS) + 1
) (
   input  logic             clk,
   input  logic             resetn,
   input  logic             in_valid_i,
   input  logic             wr_room_i,
   input  logic             frame_end_i,
   output logic             in_ready_o,
   output logic             wr_en_o,
   output logic [IDX_W-1:0] wr_count_o
);

   localparam logic [IDX_W-1:0] FRAME_LAST = IDX_W'(FRAME_WORDS);

   // words accepted in the current frame
   logic [IDX_W-1:0] wr_count;

   // low through reset, high from the first cycle after it
   logic armed;

   logic frame_full;

   //////////////////////////////
   // acceptance
   //////////////////////////////

   // whole frame in, wait for the window side to finish
   assign frame_full = (wr_count == FRAME_LAST);

   assign in_ready_o = armed && wr_room_i && !frame_full;
   assign wr_en_o    = in_valid_i && in_ready_o;
   assign wr_count_o = wr_count;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         armed <= 1'b0;
      end else begin
         armed <= 1'b1;
      end
   end

   //////////////////////////////
   // absolute write count
   //////////////////////////////

   // frame_end only arrives while the count sits at FRAME_WORDS,
   // so a handshake never coincides with the return to zero
   always_ff @(posedge clk) begin
      if (!resetn || frame_end_i) begin
         wr_count <= '0;
      end else if (wr_en_o) begin
         wr_count <= wr_count + IDX_W'(1);
      end
   end

   // window side ends a frame only once every word is in
   a_end_when_full : assert property (
      @(posedge clk) disable iff (!resetn)
      frame_end_i |-> frame_full
   ) else $error("frame end at write count 0x%0h", wr_count);

endmodule
